// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = dance_floor_tb
RTL_TOP   = dance_floor
FILELIST  = dance_floor.f
OBJ_DIR   = obj_dir
SIM_EXE   = sim_exe
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_EXE)
	$(OBJ_DIR)/$(SIM_EXE) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dance_floor.f
source/dance_pkg.sv
source/dance_cue_if.sv
source/dancer_pos_if.sv
source/beat_tracker.sv
source/dancer_motion.sv
source/sprite_position_bank.sv
source/dance_floor.sv
verification/dance_floor_tb.sv

// File: source/beat_tracker.sv
/*
  finds beats as upward threshold crossings of the audio power stream
  only samples with audio_valid high are compared; others are ignored
  a crossing on the first valid sample after reset counts as a beat
*/
module beat_tracker import dance_pkg::*; (
  input  logic                   frame_clk,
  input  logic                   reset,
  input  logic                   frame_tick,
  input  logic                   audio_valid,
  input  logic [power_width-1:0] audio_power,
  dance_cue_if.source            cue
);

  logic                     above;
  logic                     above_q;
  logic                     crossing;
  logic                     beat_hit_q;
  logic                     beating_q;
  logic                     direction_q;
  logic                     frame_tick_q;
  logic [timeout_width-1:0] quiet_cnt_q;
  logic                     quiet_done;

  // current sample at or above the beat level
  assign above = audio_power >= beat_threshold;
  // rising crossing relative to the previous valid sample
  assign crossing = audio_valid && above && !above_q;
  // last frame of the quiet window
  assign quiet_done = frame_tick &&
                      (quiet_cnt_q == timeout_width'(beat_timeout_frames - 1));

  // previous valid sample's threshold flag
  always_ff @(posedge frame_clk) begin
    if (reset) begin
      above_q <= 1'b0;
    end else if (audio_valid) begin
      above_q <= above;
    end
  end

  // beat pulse, direction flip and frame strobe copy
  always_ff @(posedge frame_clk) begin
    if (reset) begin
      beat_hit_q   <= 1'b0;
      direction_q  <= 1'b0;
      frame_tick_q <= 1'b0;
    end else begin
      beat_hit_q   <= crossing;
      direction_q  <= direction_q ^ crossing;
      frame_tick_q <= frame_tick;
    end
  end

  // music-present level restarted by every beat
  always_ff @(posedge frame_clk) begin
    if (reset) begin
      beating_q   <= 1'b0;
      quiet_cnt_q <= '0;
    end else if (crossing) begin
      beating_q   <= 1'b1;
      quiet_cnt_q <= '0;
    end else if (beating_q && frame_tick) begin
      if (quiet_done) begin
        // timeout reached so music counts as stopped
        beating_q   <= 1'b0;
        quiet_cnt_q <= '0;
      end else begin
        quiet_cnt_q <= quiet_cnt_q + 1'b1;
      end
    end
  end

  assign cue.frame_tick = frame_tick_q;
  assign cue.beat_hit   = beat_hit_q;
  assign cue.beating    = beating_q;
  assign cue.direction  = direction_q;

  // a beat needs a below-threshold sample in between so pulses never touch
  assert property (@(posedge frame_clk) disable iff (reset)
    beat_hit_q |=> !beat_hit_q);

endmodule

// File: source/dance_cue_if.sv
/*
  beat cue shared by the tracker and every dancer
  all members are single-cycle strobes or levels with no handshake
*/
interface dance_cue_if;
  // frame strobe, one cycle behind the top-level frame_tick
  logic frame_tick;
  // one-cycle pulse per detected beat
  logic beat_hit;
  // high while music is playing
  logic beating;
  // 1 steps toward +x/+y, 0 toward -x/-y
  logic direction;

  modport source (output frame_tick, beat_hit, beating, direction);
  modport sink (input frame_tick, beat_hit, beating, direction);
endinterface

// File: source/dance_floor.sv
/*
  dance-floor motion controller top level, all on frame_clk
  frame_tick is a one-cycle strobe at each frame start
  positions change 3 cycles after the qualifying frame_tick
  reset must last at least two cycles; home_x/home_y are sampled during it
*/
module dance_floor import dance_pkg::*; (
  input  logic                                frame_clk,
  input  logic                                reset,
  input  logic                                frame_tick,
  input  logic                                audio_valid,
  input  logic [power_width-1:0]              audio_power,
  input  logic [num_dancers-1:0]              dancer_en,
  input  logic [num_dancers-1:0][x_width-1:0] home_x,
  input  logic [num_dancers-1:0][y_width-1:0] home_y,
  input  logic [x_width-1:0]                  pixel_x,
  input  logic [y_width-1:0]                  pixel_y,
  output logic [num_dancers-1:0][x_width-1:0] dancer_x,
  output logic [num_dancers-1:0][y_width-1:0] dancer_y,
  output logic                                hit_valid,
  output logic [index_width-1:0]              hit_index,
  output logic                                beating,
  output logic                                beat_hit,
  output logic                                direction
);

  dance_cue_if  cue ();
  dancer_pos_if pos_bus [num_dancers] ();

  beat_tracker beat_tracker_inst (
    .frame_clk   (frame_clk),
    .reset       (reset),
    .frame_tick  (frame_tick),
    .audio_valid (audio_valid),
    .audio_power (audio_power),
    .cue         (cue)
  );

  // identical dancers, all following the same cue
  for (genvar i = 0; i < num_dancers; i++) begin : g_dancer
    dancer_motion dancer_motion_inst (
      .frame_clk (frame_clk),
      .reset     (reset),
      .enable    (dancer_en[i]),
      .home_x    (home_x[i]),
      .home_y    (home_y[i]),
      .cue       (cue),
      .pos       (pos_bus[i])
    );
  end

  sprite_position_bank sprite_position_bank_inst (
    .frame_clk (frame_clk),
    .reset     (reset),
    .pixel_x   (pixel_x),
    .pixel_y   (pixel_y),
    .pos       (pos_bus),
    .dancer_x  (dancer_x),
    .dancer_y  (dancer_y),
    .hit_valid (hit_valid),
    .hit_index (hit_index)
  );

  // cue status for the outside
  assign beating   = cue.beating;
  assign beat_hit  = cue.beat_hit;
  assign direction = cue.direction;

endmodule

// File: source/dance_pkg.sv
/*
  shared sizes and timing for the dance-floor motion controller
  all timing constants count frame_tick strobes, not clock cycles
  num_dancers, step_frames and max_tol may be changed; derived widths follow
*/
package dance_pkg;

  // dancer count and screen coordinate widths
  localparam int num_dancers = 4;
  localparam int x_width = 10;
  localparam int y_width = 9;
  localparam int index_width = (num_dancers > 1) ? $clog2(num_dancers) : 1;

  // audio power samples and the level whose upward crossing is a beat
  localparam int power_width = 11;
  localparam logic [power_width-1:0] beat_threshold = power_width'(600);

  // frames without a beat before music counts as stopped
  localparam int beat_timeout_frames = 16;
  localparam int timeout_width = $clog2(beat_timeout_frames + 1);

  // frames between two steps, and the largest offset from home per axis
  localparam int step_frames = 8;
  localparam int step_cnt_width = (step_frames > 1) ? $clog2(step_frames) : 1;
  localparam int max_tol = 7;

  // sprite box for the pixel hit test
  localparam int sprite_w = 32;
  localparam int sprite_h = 32;

endpackage

// File: source/dancer_motion.sv
/*
  one dancer's diagonal sway around its home position
  home is captured while reset is high; later changes wait for the next reset
  reset must be held at least two cycles for the bank to see home
  each axis clamps to home +/- max_tol and never wraps at the screen edge
*/
module dancer_motion import dance_pkg::*; (
  input  logic               frame_clk,
  input  logic               reset,
  input  logic               enable,
  input  logic [x_width-1:0] home_x,
  input  logic [y_width-1:0] home_y,
  dance_cue_if.sink          cue,
  dancer_pos_if.dancer       pos
);

  logic [step_cnt_width-1:0] frame_cnt_q;
  logic                      run;
  logic                      step;
  logic [x_width-1:0]        home_x_q;
  logic [y_width-1:0]        home_y_q;
  logic [x_width-1:0]        pos_x_q;
  logic [y_width-1:0]        pos_y_q;
  // one extra bit so the box bounds never wrap
  logic [x_width:0]          pos_x_ext;
  logic [x_width:0]          home_x_ext;
  logic [x_width:0]          x_hi;
  logic [x_width:0]          x_reach;
  logic [y_width:0]          pos_y_ext;
  logic [y_width:0]          home_y_ext;
  logic [y_width:0]          y_hi;
  logic [y_width:0]          y_reach;
  logic                      x_can_inc;
  logic                      x_can_dec;
  logic                      y_can_inc;
  logic                      y_can_dec;
  logic                      x_go;
  logic                      y_go;
  logic                      moved_q;
  logic                      active_q;

  assign run  = enable && cue.beating;
  // step on the step_frames-th counted frame
  assign step = run && cue.frame_tick &&
                (frame_cnt_q == step_cnt_width'(step_frames - 1));

  assign pos_x_ext  = {1'b0, pos_x_q};
  assign home_x_ext = {1'b0, home_x_q};
  assign pos_y_ext  = {1'b0, pos_y_q};
  assign home_y_ext = {1'b0, home_y_q};

  // upper box edge per axis
  assign x_hi = home_x_ext + (x_width + 1)'(max_tol);
  assign y_hi = home_y_ext + (y_width + 1)'(max_tol);
  // position plus tolerance is compared with home for the lower edge
  assign x_reach = pos_x_ext + (x_width + 1)'(max_tol);
  assign y_reach = pos_y_ext + (y_width + 1)'(max_tol);

  // room left inside the tolerance box and on screen
  assign x_can_inc = (pos_x_ext < x_hi) && (pos_x_q != '1);
  assign x_can_dec = (x_reach > home_x_ext) && (pos_x_q != '0);
  assign y_can_inc = (pos_y_ext < y_hi) && (pos_y_q != '1);
  assign y_can_dec = (y_reach > home_y_ext) && (pos_y_q != '0);

  // each axis moves only if the cue direction leaves room
  assign x_go = cue.direction ? x_can_inc : x_can_dec;
  assign y_go = cue.direction ? y_can_inc : y_can_dec;

  // frame counter cleared whenever the dancer is idle
  always_ff @(posedge frame_clk) begin
    if (reset || !run) begin
      frame_cnt_q <= '0;
    end else if (cue.frame_tick) begin
      if (step) begin
        frame_cnt_q <= '0;
      end else begin
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  // home copy and position
  always_ff @(posedge frame_clk) begin
    if (reset) begin
      home_x_q <= home_x;
      home_y_q <= home_y;
      pos_x_q  <= home_x;
      pos_y_q  <= home_y;
    end else if (step) begin
      if (x_go) begin
        pos_x_q <= cue.direction ? pos_x_q + 1'b1 : pos_x_q - 1'b1;
      end
      if (y_go) begin
        pos_y_q <= cue.direction ? pos_y_q + 1'b1 : pos_y_q - 1'b1;
      end
    end
  end

  // status flags aligned with the position update
  always_ff @(posedge frame_clk) begin
    if (reset) begin
      moved_q  <= 1'b0;
      active_q <= 1'b0;
    end else begin
      moved_q  <= step && (x_go || y_go);
      active_q <= run;
    end
  end

  assign pos.pos_x  = pos_x_q;
  assign pos.pos_y  = pos_y_q;
  assign pos.moved  = moved_q;
  assign pos.active = active_q;

  // position stays inside home +/- max_tol on both axes
  assert property (@(posedge frame_clk) disable iff (reset)
    (pos_x_ext <= x_hi) && (x_reach >= home_x_ext) &&
    (pos_y_ext <= y_hi) && (y_reach >= home_y_ext));

endmodule

// File: source/dancer_pos_if.sv
/*
  one dancer's sprite position and status toward the position bank
  pos_x and pos_y are the sprite's top-left corner
*/
interface dancer_pos_if import dance_pkg::*; ();
  logic [x_width-1:0] pos_x;
  logic [y_width-1:0] pos_y;
  // pulses in the cycle the new position first shows
  logic moved;
  // enabled and music playing, registered
  logic active;

  modport dancer (output pos_x, pos_y, moved, active);
  modport bank (input pos_x, pos_y, moved, active);
endinterface

// File: source/sprite_position_bank.sv
/*
  collects every dancer position and answers which sprite covers a pixel
  hit test uses the registered positions, result one cycle after the pixel
  overlapping sprites resolve to the lowest dancer index
*/
module sprite_position_bank import dance_pkg::*; (
  input  logic                                frame_clk,
  input  logic                                reset,
  input  logic [x_width-1:0]                  pixel_x,
  input  logic [y_width-1:0]                  pixel_y,
  dancer_pos_if.bank                          pos [num_dancers],
  output logic [num_dancers-1:0][x_width-1:0] dancer_x,
  output logic [num_dancers-1:0][y_width-1:0] dancer_y,
  output logic                                hit_valid,
  output logic [index_width-1:0]              hit_index
);

  logic [num_dancers-1:0][x_width-1:0] live_x;
  logic [num_dancers-1:0][y_width-1:0] live_y;
  logic [num_dancers-1:0]              live_moved;
  logic [num_dancers-1:0]              covers;
  logic                                hit_any;
  logic [index_width-1:0]              hit_sel;

  for (genvar i = 0; i < num_dancers; i++) begin : g_dancer
    assign live_x[i]     = pos[i].pos_x;
    assign live_y[i]     = pos[i].pos_y;
    assign live_moved[i] = pos[i].moved;

    // box spans pos to pos + size - 1 and is compared one bit wider
    assign covers[i] =
      ({1'b0, pixel_x} >= {1'b0, dancer_x[i]}) &&
      ({1'b0, pixel_x} < {1'b0, dancer_x[i]} + (x_width + 1)'(sprite_w)) &&
      ({1'b0, pixel_y} >= {1'b0, dancer_y[i]}) &&
      ({1'b0, pixel_y} < {1'b0, dancer_y[i]} + (y_width + 1)'(sprite_h));

    // an idle dancer's registered copy is already up to date
    assert property (@(posedge frame_clk) disable iff (reset)
      !pos[i].active |-> (dancer_x[i] == live_x[i]) && (dancer_y[i] == live_y[i]));
  end

  // load on every step; during reset this picks up the home positions
  always_ff @(posedge frame_clk) begin
    for (int i = 0; i < num_dancers; i++) begin
      if (reset || live_moved[i]) begin
        dancer_x[i] <= live_x[i];
        dancer_y[i] <= live_y[i];
      end
    end
  end

  // scan from the top so the lowest covering index wins
  always_comb begin
    hit_any = 1'b0;
    hit_sel = '0;
    for (int i = num_dancers - 1; i >= 0; i--) begin
      if (covers[i]) begin
        hit_any = 1'b1;
        hit_sel = index_width'(i);
      end
    end
  end

  always_ff @(posedge frame_clk) begin
    if (reset) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= hit_any;
    end
  end

  // index only means something while hit_valid is high
  always_ff @(posedge frame_clk) begin
    hit_index <= hit_sel;
  end

endmodule

// File: verification/dance_floor_tb.sv
/*
  directed tests for the dance-floor controller written for four dancers
  inputs change and outputs are read 1 ns after the rising edge
  dancers 0 and 2 are enabled; homes are spaced so sprites 0 and 1 overlap
*/
module dance_floor_tb import dance_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int move_timeout = 20;

  logic                                frame_clk;
  logic                                reset;
  logic                                frame_tick;
  logic                                audio_valid;
  logic [power_width-1:0]              audio_power;
  logic [num_dancers-1:0]              dancer_en;
  logic [num_dancers-1:0][x_width-1:0] home_x;
  logic [num_dancers-1:0][y_width-1:0] home_y;
  logic [x_width-1:0]                  pixel_x;
  logic [y_width-1:0]                  pixel_y;
  logic [num_dancers-1:0][x_width-1:0] dancer_x;
  logic [num_dancers-1:0][y_width-1:0] dancer_y;
  logic                                hit_valid;
  logic [index_width-1:0]              hit_index;
  logic                                beating;
  logic                                beat_hit;
  logic                                direction;

  int          value_errors;
  int          timeout_errors;
  logic [15:0] lfsr_state;
  // reference model of cue and dancer positions
  int          home_x_val [num_dancers];
  int          home_y_val [num_dancers];
  int          model_x [num_dancers];
  int          model_y [num_dancers];
  bit          exp_dir;
  bit          exp_beating;
  bit          prev_above;
  int          exp_quiet;
  int          step_cnt;

  dance_floor dance_floor_inst (.*);

  initial begin
    frame_clk = 1'b0;
    forever #5 frame_clk = ~frame_clk;
  end

  // one clock and then settle past the edge
  task automatic step_cycle();
    @(posedge frame_clk);
    #1;
  endtask

  task automatic expect_value(input string name, input int actual, input int expected);
    assert (actual == expected) else begin
      value_errors++;
      $display("Error at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // one valid sample; beat_hit must follow exactly one cycle later
  task automatic send_sample(input int power);
    bit above;
    bit crossing;
    above = power >= int'(beat_threshold);
    crossing = above && !prev_above;
    prev_above = above;
    if (crossing) begin
      exp_dir = !exp_dir;
      exp_beating = 1'b1;
      exp_quiet = 0;
    end
    audio_valid = 1'b1;
    audio_power = power_width'(power);
    step_cycle();
    expect_value("beat_hit", int'(beat_hit), int'(crossing));
    expect_value("direction", int'(direction), int'(exp_dir));
    expect_value("beating", int'(beating), int'(exp_beating));
    audio_valid = 1'b0;
  endtask

  // beat and then a quiet sample so the next one can cross again
  task automatic single_beat();
    send_sample(int'(beat_threshold) + 50);
    send_sample(random_bits(9));
  endtask

  // two beats leave direction where it was
  task automatic double_beat();
    single_beat();
    single_beat();
  endtask

  // diagonal step of every enabled dancer that holds an axis at home +/- max_tol
  task automatic predict_step();
    int delta;
    delta = exp_dir ? 1 : -1;
    for (int i = 0; i < num_dancers; i++) begin
      if (dancer_en[i]) begin
        if ((model_x[i] + delta <= home_x_val[i] + max_tol) &&
            (model_x[i] + delta >= home_x_val[i] - max_tol)) begin
          model_x[i] += delta;
        end
        if ((model_y[i] + delta <= home_y_val[i] + max_tol) &&
            (model_y[i] + delta >= home_y_val[i] - max_tol)) begin
          model_y[i] += delta;
        end
      end
    end
  endtask

  // quiet timeout first so the dancers count with the updated level
  task automatic track_frame();
    if (exp_beating) begin
      exp_quiet++;
      if (exp_quiet == beat_timeout_frames) begin
        exp_beating = 1'b0;
        exp_quiet = 0;
      end
    end
    if (exp_beating) begin
      step_cnt++;
      if (step_cnt == step_frames) begin
        predict_step();
        step_cnt = 0;
      end
    end else begin
      step_cnt = 0;
    end
  endtask

  task automatic compare_positions();
    for (int i = 0; i < num_dancers; i++) begin
      expect_value($sformatf("dancer_x[%0d]", i), int'(dancer_x[i]), model_x[i]);
      expect_value($sformatf("dancer_y[%0d]", i), int'(dancer_y[i]), model_y[i]);
    end
  endtask

  task automatic pulse_frame();
    frame_tick = 1'b1;
    step_cycle();
    frame_tick = 1'b0;
  endtask

  task automatic send_frames(input int count);
    repeat (count) begin
      pulse_frame();
      track_frame();
      // step reaches the bank outputs 3 cycles after the tick
      repeat (3) step_cycle();
      compare_positions();
      expect_value("beating", int'(beating), int'(exp_beating));
    end
  endtask

  // sprite box spans pos to pos + size - 1 on each axis
  function automatic bit box_covers(input int px, input int py, input int i);
    return (px >= int'(dancer_x[i])) && (px < int'(dancer_x[i]) + sprite_w) &&
           (py >= int'(dancer_y[i])) && (py < int'(dancer_y[i]) + sprite_h);
  endfunction

  task automatic probe_pixel(input int px, input int py);
    bit exp_valid;
    int exp_index;
    exp_valid = 1'b0;
    exp_index = 0;
    // first covering dancer in index order
    for (int i = 0; i < num_dancers; i++) begin
      if (!exp_valid && box_covers(px, py, i)) begin
        exp_valid = 1'b1;
        exp_index = i;
      end
    end
    pixel_x = x_width'(px);
    pixel_y = y_width'(py);
    step_cycle();
    expect_value("hit_valid", int'(hit_valid), int'(exp_valid));
    if (exp_valid) begin
      expect_value("hit_index", int'(hit_index), exp_index);
    end
  endtask

  task automatic check_reset_state();
    compare_positions();
    expect_value("beating", int'(beating), 0);
    expect_value("beat_hit", int'(beat_hit), 0);
    expect_value("direction", int'(direction), 0);
    expect_value("hit_valid", int'(hit_valid), 0);
  endtask

  task automatic detect_beats();
    // a sample exactly at the threshold counts and flips direction from reset
    send_sample(int'(beat_threshold));
    expect_value("direction", int'(direction), 1);
    // still above so no new pulse
    send_sample(int'(beat_threshold) + 200);
    // 9 random bits stay below the threshold
    repeat (20) begin
      send_sample(random_bits(9));
    end
  endtask

  task automatic step_enabled_dancers();
    int old_x;
    int cycles;
    send_frames(step_frames - 1);
    old_x = int'(dancer_x[0]);
    pulse_frame();
    track_frame();
    cycles = 1;
    while ((int'(dancer_x[0]) == old_x) && (cycles < move_timeout)) begin
      step_cycle();
      cycles++;
    end
    assert (cycles < move_timeout) else begin
      timeout_errors++;
      $display("Timeout: dancer 0 did not step within %0d cycles", move_timeout);
    end
    expect_value("step latency", cycles, 3);
    expect_value("dancer_x[0]", int'(dancer_x[0]), home_x_val[0] + (exp_dir ? 1 : -1));
    expect_value("dancer_y[2]", int'(dancer_y[2]), home_y_val[2] + (exp_dir ? 1 : -1));
    // disabled dancers 1 and 3 must still sit at home
    compare_positions();
  endtask

  task automatic clamp_at_tolerance();
    // more steps than the tolerance allows while beats keep music alive
    repeat (max_tol + 2) begin
      double_beat();
      send_frames(step_frames);
    end
    expect_value("dancer_x[0]", int'(dancer_x[0]), home_x_val[0] + max_tol);
    expect_value("dancer_y[0]", int'(dancer_y[0]), home_y_val[0] + max_tol);
    expect_value("dancer_x[2]", int'(dancer_x[2]), home_x_val[2] + max_tol);
    expect_value("dancer_y[2]", int'(dancer_y[2]), home_y_val[2] + max_tol);
    // flip back toward home
    single_beat();
    expect_value("direction", int'(direction), 0);
    send_frames(step_frames);
    expect_value("dancer_x[0]", int'(dancer_x[0]), home_x_val[0] + max_tol - 1);
    expect_value("dancer_y[0]", int'(dancer_y[0]), home_y_val[0] + max_tol - 1);
  endtask

  task automatic stop_on_timeout();
    int frames;
    int held_x [num_dancers];
    int held_y [num_dancers];
    double_beat();
    frames = 0;
    while (beating && (frames < 2 * beat_timeout_frames)) begin
      send_frames(1);
      frames++;
    end
    assert (!beating) else begin
      timeout_errors++;
      $display("Timeout: beating still high after %0d frames without a beat", frames);
    end
    expect_value("frames to timeout", frames, beat_timeout_frames);
    for (int i = 0; i < num_dancers; i++) begin
      held_x[i] = int'(dancer_x[i]);
      held_y[i] = int'(dancer_y[i]);
    end
    send_frames(2 * step_frames);
    for (int i = 0; i < num_dancers; i++) begin
      expect_value($sformatf("dancer_x[%0d]", i), int'(dancer_x[i]), held_x[i]);
      expect_value($sformatf("dancer_y[%0d]", i), int'(dancer_y[i]), held_y[i]);
    end
  endtask

  task automatic resolve_pixel_hit();
    int px;
    int py;
    // just inside sprite 1 where sprite 0 overlaps it
    px = int'(dancer_x[1]) + 2;
    py = int'(dancer_y[1]) + 2;
    assert (box_covers(px, py, 0) && box_covers(px, py, 1)) else begin
      value_errors++;
      $display("Pixel test setup is wrong: the pixel is not inside sprites 0 and 1");
    end
    probe_pixel(px, py);
    expect_value("hit_index", int'(hit_index), 0);
    // far corner away from every box
    probe_pixel(1000, 500);
  endtask

  initial begin
    value_errors = 0;
    timeout_errors = 0;
    lfsr_state = 16'd99;
    exp_dir = 1'b0;
    exp_beating = 1'b0;
    prev_above = 1'b0;
    exp_quiet = 0;
    step_cnt = 0;
    reset = 1'b1;
    frame_tick = 1'b0;
    audio_valid = 1'b0;
    audio_power = '0;
    dancer_en = '0;
    dancer_en[0] = 1'b1;
    dancer_en[2] = 1'b1;
    pixel_x = x_width'(1000);
    pixel_y = y_width'(500);
    for (int i = 0; i < num_dancers; i++) begin
      home_x_val[i] = 100 + 20 * i;
      home_y_val[i] = 100 + 10 * i;
      model_x[i] = home_x_val[i];
      model_y[i] = home_y_val[i];
      home_x[i] = x_width'(home_x_val[i]);
      home_y[i] = y_width'(home_y_val[i]);
    end
    repeat (10) step_cycle();
    reset = 1'b0;

    check_reset_state();
    detect_beats();
    step_enabled_dancers();
    clamp_at_tolerance();
    stop_on_timeout();
    resolve_pixel_hit();

    $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
